/* logic/alu_isa_pkg.sv */
// Request side of the ALU: opcodes, operand widths and the request word.
// Operands are always 32 bits. Byte and word operations use the low bits only.
// For shifts b[3:0] holds the count and 0 stands for 16.
`default_nettype none

package alu_isa_pkg;

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_CP,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SCF,
        ALU_RCF,
        ALU_CCF,
        ALU_ZCF,
        ALU_EXFF,
        ALU_RLC,
        ALU_RRC,
        ALU_RL,
        ALU_RR,
        ALU_SLA,
        ALU_SRA,
        ALU_SLL,
        ALU_SRL,
        ALU_NOP
    } alu_op_e;

    typedef enum logic [1:0] {
        W_BYTE = 2'd0,
        W_WORD = 2'd1,
        W_LONG = 2'd2
    } alu_width_e;

    typedef struct packed {
        alu_op_e     op;
        alu_width_e  width;
        logic [31:0] a;
        logic [31:0] b;     // shift count in [3:0]
    } alu_req_t;

    function automatic logic is_shift(input alu_op_e op);
        return op inside {ALU_RLC, ALU_RRC, ALU_RL, ALU_RR,
                          ALU_SLA, ALU_SRA, ALU_SLL, ALU_SRL};
    endfunction

endpackage

`default_nettype wire

/* logic/alu_status_pkg.sv */
// Status side of the ALU: the flag word and the width-aware helpers that
// derive sign, zero and parity from a 32-bit value.
// Bits above the active width are ignored by all helpers.
`default_nettype none

package alu_status_pkg;

    typedef struct packed {
        logic s;
        logic z;
        logic h;
        logic v;    // overflow or even parity
        logic n;
        logic c;
    } alu_flags_t;

    function automatic logic width_sign(input logic [31:0] x,
                                        input alu_isa_pkg::alu_width_e w);
        case (w)
            alu_isa_pkg::W_BYTE: return x[7];
            alu_isa_pkg::W_WORD: return x[15];
            default:             return x[31];
        endcase
    endfunction

    function automatic logic width_zero(input logic [31:0] x,
                                        input alu_isa_pkg::alu_width_e w);
        case (w)
            alu_isa_pkg::W_BYTE: return x[7:0] == 8'd0;
            alu_isa_pkg::W_WORD: return x[15:0] == 16'd0;
            default:             return x == 32'd0;
        endcase
    endfunction

    function automatic logic width_even(input logic [31:0] x,
                                        input alu_isa_pkg::alu_width_e w);
        case (w)
            alu_isa_pkg::W_BYTE: return ~^x[7:0];
            alu_isa_pkg::W_WORD: return ~^x[15:0];
            default:             return ~^x;
        endcase
    endfunction

endpackage

`default_nettype wire

/* logic/alu_arith.sv */
// Single-cycle part of the ALU, purely combinational.
// Add and subtract share one adder chain built from nibble, byte and word
// segments, with subtract done as a + ~b + ~borrow.
// Bits of result above the active width are zero.
// Shifts, EXFF and NOP pass the flags through untouched.
`timescale 1ns/1ps
`default_nettype none

module alu_arith (
    input  wire alu_isa_pkg::alu_req_t      req,
    input  wire alu_status_pkg::alu_flags_t flags_cur,
    output logic [31:0]                     result,
    output alu_status_pkg::alu_flags_t      flags_nxt
);

    import alu_isa_pkg::*;
    import alu_status_pkg::*;

    logic        is_sub;
    logic        cin;
    logic [31:0] bx;
    logic [31:0] sum;
    logic        c4;
    logic        c8;
    logic        c16;
    logic        c32;
    logic        cout;
    logic [32:0] ext_sum;
    logic [31:0] mask;
    logic [31:0] logic_r;

    function automatic logic [32:0] sext(input logic [31:0] x, input alu_width_e w);
        case (w)
            W_BYTE:  return {{25{x[7]}}, x[7:0]};
            W_WORD:  return {{17{x[15]}}, x[15:0]};
            default: return {x[31], x};
        endcase
    endfunction

    always_comb begin
        is_sub = req.op inside {ALU_SUB, ALU_SBC, ALU_CP};
        if (is_sub) begin
            cin = !(req.op == ALU_SBC && flags_cur.c);  // inverted borrow
        end else begin
            cin = req.op == ALU_ADC && flags_cur.c;
        end
        bx = is_sub ? ~req.b : req.b;

        {c4,  sum[3:0]}   = {1'b0, req.a[3:0]}   + {1'b0, bx[3:0]}   + {4'd0, cin};
        {c8,  sum[7:4]}   = {1'b0, req.a[7:4]}   + {1'b0, bx[7:4]}   + {4'd0, c4};
        {c16, sum[15:8]}  = {1'b0, req.a[15:8]}  + {1'b0, bx[15:8]}  + {8'd0, c8};
        {c32, sum[31:16]} = {1'b0, req.a[31:16]} + {1'b0, bx[31:16]} + {16'd0, c16};

        // sign-extended copy, bit 32 disagrees with the msb on overflow
        ext_sum = sext(req.a, req.width) + sext(bx, req.width) + {32'd0, cin};

        case (req.width)
            W_BYTE: begin
                cout = c8;
                mask = 32'h0000_00ff;
            end
            W_WORD: begin
                cout = c16;
                mask = 32'h0000_ffff;
            end
            default: begin
                cout = c32;
                mask = 32'hffff_ffff;
            end
        endcase

        case (req.op)
            ALU_AND: logic_r = req.a & req.b;
            ALU_OR:  logic_r = req.a | req.b;
            default: logic_r = req.a ^ req.b;
        endcase
    end

    always_comb begin
        result    = req.a;
        flags_nxt = flags_cur;
        case (req.op)
            ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP: begin
                result      = sum & mask;   // CP result is dropped later
                flags_nxt.s = width_sign(sum, req.width);
                flags_nxt.z = width_zero(sum, req.width);
                flags_nxt.h = c4 ^ is_sub;
                flags_nxt.v = ext_sum[32] ^ width_sign(sum, req.width);
                flags_nxt.n = is_sub;
                flags_nxt.c = cout ^ is_sub;
            end
            ALU_AND, ALU_OR, ALU_XOR: begin
                result      = logic_r & mask;
                flags_nxt.s = width_sign(logic_r, req.width);
                flags_nxt.z = width_zero(logic_r, req.width);
                flags_nxt.h = req.op == ALU_AND;
                flags_nxt.v = width_even(logic_r, req.width);
                flags_nxt.n = 1'b0;
                flags_nxt.c = 1'b0;
            end
            ALU_SCF: begin
                flags_nxt.h = 1'b0;
                flags_nxt.n = 1'b0;
                flags_nxt.c = 1'b1;
            end
            ALU_RCF: begin
                flags_nxt.h = 1'b0;
                flags_nxt.n = 1'b0;
                flags_nxt.c = 1'b0;
            end
            ALU_CCF: begin
                flags_nxt.n = 1'b0;     // h kept
                flags_nxt.c = ~flags_cur.c;
            end
            ALU_ZCF: begin
                flags_nxt.n = 1'b0;
                flags_nxt.c = ~flags_cur.z;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* logic/alu_shifter.sv */
// Shift and rotate engine, one bit per clock inside the active width.
// Loads a and the count on start. done is high in the cycle of the last
// step, and result and flags show the value after that step, so they are
// only meaningful while done is high.
// Bits above the active width are cleared on load and stay zero.
`timescale 1ns/1ps
`default_nettype none

module alu_shifter (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         start,
    input  wire alu_isa_pkg::alu_req_t  req,
    input  wire                         carry_in,
    output logic                        busy,
    output logic                        done,
    output logic [31:0]                 result,
    output alu_status_pkg::alu_flags_t  flags
);

    import alu_isa_pkg::*;
    import alu_status_pkg::*;

    logic [4:0]  cnt;
    logic [31:0] data;
    logic        c_q;
    alu_op_e     op_q;
    alu_width_e  width_q;
    logic [4:0]  msb;
    logic        lsb_in;
    logic        msb_in;
    logic [31:0] step_data;
    logic        step_c;

    function automatic logic [31:0] width_mask(input alu_width_e w);
        case (w)
            W_BYTE:  return 32'h0000_00ff;
            W_WORD:  return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    always_comb begin
        case (width_q)
            W_BYTE:  msb = 5'd7;
            W_WORD:  msb = 5'd15;
            default: msb = 5'd31;
        endcase

        case (op_q)
            ALU_RLC: lsb_in = data[msb];
            ALU_RL:  lsb_in = c_q;      // through carry
            default: lsb_in = 1'b0;
        endcase

        case (op_q)
            ALU_RRC: msb_in = data[0];
            ALU_RR:  msb_in = c_q;
            ALU_SRA: msb_in = data[msb];    // sign repeats
            default: msb_in = 1'b0;
        endcase

        if (op_q inside {ALU_RLC, ALU_RL, ALU_SLA, ALU_SLL}) begin
            step_c    = data[msb];
            step_data = {data[30:0], lsb_in} & width_mask(width_q);
        end else begin
            step_c         = data[0];
            step_data      = {1'b0, data[31:1]};
            step_data[msb] = msb_in;
        end
    end

    assign done   = busy && cnt == 5'd1;
    assign result = step_data;

    always_comb begin
        flags.s = width_sign(step_data, width_q);
        flags.z = width_zero(step_data, width_q);
        flags.h = 1'b0;
        flags.v = width_even(step_data, width_q);
        flags.n = 1'b0;
        flags.c = step_c;   // last bit out
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= 5'd0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= {req.b[3:0] == 4'd0, req.b[3:0]};  // 0 means 16
        end else if (busy) begin
            cnt <= cnt - 5'd1;
            if (cnt == 5'd1) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            data    <= req.a & width_mask(req.width);
            c_q     <= carry_in;
            op_q    <= req.op;
            width_q <= req.width;
        end else if (busy) begin
            data <= step_data;
            c_q  <= step_c;
        end
    end

    // the issue logic upstream must hold new shifts off until this one ends
    a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

`default_nettype wire

/* logic/alu_flag_reg.sv */
// Issue control plus the architectural result, flag and shadow flag registers.
// One request at a time: a request is taken when req_valid is high and busy
// is low, and the requester must not raise req_valid while busy is high.
// CP, the flag operations, EXFF and NOP leave result unchanged.
`timescale 1ns/1ps
`default_nettype none

module alu_flag_reg (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             req_valid,
    input  wire alu_isa_pkg::alu_req_t      req,
    input  wire [31:0]                      arith_result,
    input  wire alu_status_pkg::alu_flags_t arith_flags,
    input  wire                             shift_busy,
    input  wire                             shift_done,
    input  wire [31:0]                      shift_result,
    input  wire alu_status_pkg::alu_flags_t shift_flags,
    output logic                            busy,
    output logic                            shift_start,
    output alu_status_pkg::alu_flags_t      flags_cur,
    output logic                            rsp_valid,
    output logic [31:0]                     result
);

    import alu_isa_pkg::*;
    import alu_status_pkg::*;

    logic       accept;
    logic       req_shift;
    logic       single;
    logic       writes_result;
    alu_flags_t shadow;

    assign busy          = shift_busy;
    assign accept        = req_valid && !busy;
    assign req_shift     = is_shift(req.op);
    assign single        = accept && !req_shift;
    assign shift_start   = accept && req_shift;
    assign writes_result = req.op inside {ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
                                          ALU_AND, ALU_OR, ALU_XOR};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            result    <= 32'd0;
            flags_cur <= '0;
            shadow    <= '0;
        end else begin
            rsp_valid <= single || shift_done;
            if (shift_done) begin
                result    <= shift_result;
                flags_cur <= shift_flags;
            end else if (single) begin
                if (writes_result) begin
                    result <= arith_result;
                end
                if (req.op == ALU_EXFF) begin
                    flags_cur <= shadow;    // swap F and F'
                    shadow    <= flags_cur;
                end else begin
                    flags_cur <= arith_flags;
                end
            end
        end
    end

    a_no_req_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !req_valid);

    // the shift response lands the cycle after the shifter drops busy
    a_rsp_idle: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> !busy);

endmodule

`default_nettype wire

/* logic/alu_top.sv */
// Top level of the 32-bit ALU.
// Single-cycle operations answer one clock after acceptance. A shift by n
// holds busy for n cycles and answers n+1 clocks after acceptance.
// rsp_valid is a one-cycle pulse with no back-pressure.
`timescale 1ns/1ps
`default_nettype none

module alu_top (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         req_valid,
    input  wire alu_isa_pkg::alu_req_t  req,
    output logic                        busy,
    output logic                        rsp_valid,
    output logic [31:0]                 result,
    output alu_status_pkg::alu_flags_t  flags
);

    import alu_status_pkg::*;

    wire [31:0]      arith_result;
    wire alu_flags_t arith_flags;
    wire             shift_start;
    wire             shift_busy;
    wire             shift_done;
    wire [31:0]      shift_result;
    wire alu_flags_t shift_flags;

    alu_arith u_arith (
        .req       (req),
        .flags_cur (flags),
        .result    (arith_result),
        .flags_nxt (arith_flags)
    );

    alu_shifter u_shifter (
        .clk      (clk),
        .rst      (rst),
        .start    (shift_start),
        .req      (req),
        .carry_in (flags.c),
        .busy     (shift_busy),
        .done     (shift_done),
        .result   (shift_result),
        .flags    (shift_flags)
    );

    alu_flag_reg u_flag_reg (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .arith_result (arith_result),
        .arith_flags  (arith_flags),
        .shift_busy   (shift_busy),
        .shift_done   (shift_done),
        .shift_result (shift_result),
        .shift_flags  (shift_flags),
        .busy         (busy),
        .shift_start  (shift_start),
        .flags_cur    (flags),
        .rsp_valid    (rsp_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

/* verification/alu_tests.svh */
// Directed tests, included inside alu_tb.
// Each task leaves req_valid low and returns on a falling edge.

task automatic test_arith();
    logic [31:0] bnd [8];
    int          wi;
    int          oi;
    int          i;
    bnd = '{32'h0, 32'h1, 32'h7f, 32'h80, 32'hff, 32'h7fff, 32'h8000_0000, 32'hffff_ffff};
    for (wi = 0; wi < 3; wi++) begin
        for (oi = int'(ALU_ADD); oi <= int'(ALU_CP); oi++) begin
            for (i = 0; i < 8; i++) begin
                run_op(alu_op_e'(oi), alu_width_e'(wi), bnd[i], bnd[7 - i]);
                run_op(alu_op_e'(oi), alu_width_e'(wi), bnd[i], bnd[i]);  // equal operands
                run_op(alu_op_e'(oi), alu_width_e'(wi), next_rand(), next_rand());
            end
        end
    end
    finish_test("arith");
endtask

task automatic test_logic();
    logic [31:0] a;
    int          wi;
    int          oi;
    int          i;
    for (wi = 0; wi < 3; wi++) begin
        for (oi = int'(ALU_AND); oi <= int'(ALU_XOR); oi++) begin
            for (i = 0; i < 6; i++) begin
                a = next_rand();
                if (i == 4) begin
                    run_op(alu_op_e'(oi), alu_width_e'(wi), a, a);
                end else if (i == 5) begin
                    run_op(alu_op_e'(oi), alu_width_e'(wi), a, ~a);
                end else begin
                    run_op(alu_op_e'(oi), alu_width_e'(wi), a, next_rand());
                end
            end
        end
    end
    finish_test("logic");
endtask

task automatic test_flag_ops();
    logic [31:0] a;
    logic [31:0] b;
    alu_flags_t  saved;
    int          i;
    apply_reset();
    run_op(ALU_EXFF, W_LONG, next_rand(), 32'd0);
    check_val("flags after first exff", {26'd0, flags}, 32'd0);
    for (i = 0; i < 8; i++) begin
        a = next_rand();
        b = (i % 2 == 0) ? a : next_rand();     // equal operands so SUB gives z
        run_op(alu_op_e'(i % 4), alu_width_e'(i % 3), a, b);
        run_op(ALU_ZCF, W_LONG, a, 32'd0);
        run_op(ALU_CCF, W_LONG, a, 32'd0);
        run_op(ALU_SCF, W_LONG, a, 32'd0);
        run_op(ALU_RCF, W_LONG, a, 32'd0);
    end
    run_op(ALU_SUB, W_BYTE, 32'h10, 32'h21);
    saved = m_flags;
    run_op(ALU_EXFF, W_LONG, 32'd0, 32'd0);
    run_op(ALU_EXFF, W_LONG, 32'd0, 32'd0);
    check_val("flags after two exff", {26'd0, flags}, {26'd0, saved});
    finish_test("flag ops");
endtask

task automatic test_shifts();
    logic [3:0] cnt4 [3];
    int         wi;
    int         oi;
    int         ci;
    cnt4 = '{4'd1, 4'd5, 4'd0};     // 0 is a count of 16
    for (wi = 0; wi < 3; wi++) begin
        for (oi = int'(ALU_RLC); oi <= int'(ALU_SRL); oi++) begin
            for (ci = 0; ci < 3; ci++) begin
                run_op(alu_op_e'(oi), alu_width_e'(wi), next_rand(),
                       (next_rand() & 32'hffff_fff0) | {28'd0, cnt4[ci]});
            end
        end
    end
    finish_test("shifts");
endtask

task automatic test_handshake();
    alu_op_e     seq [4];
    logic [31:0] exp_res [4];
    alu_flags_t  exp_flg [4];
    logic [31:0] a;
    logic [31:0] b;
    int          lat;
    int          i;
    int          busy_cycles;
    seq = '{ALU_ADD, ALU_XOR, ALU_SBC, ALU_CP};
    for (i = 0; i < 4; i++) begin
        a = next_rand();
        b = next_rand();
        model_step(seq[i], W_LONG, a, b, lat);
        exp_res[i] = m_result;
        exp_flg[i] = m_flags;
        drive_req(seq[i], W_LONG, a, b);
        @(negedge clk);
        if (i > 0) begin
            check_rsp(exp_res[i - 1], exp_flg[i - 1]);
        end
    end
    @(posedge clk);
    req_valid <= 1'b0;
    @(negedge clk);
    check_rsp(exp_res[3], exp_flg[3]);
    @(negedge clk);
    check_val("rsp_valid after burst", {31'd0, rsp_valid}, 32'd0);

    a = next_rand();
    model_step(ALU_RRC, W_WORD, a, 32'd5, lat);
    drive_req(ALU_RRC, W_WORD, a, 32'd5);
    @(posedge clk);
    req_valid <= 1'b0;
    busy_cycles = 0;
    @(negedge clk);
    while (busy === 1'b1 && busy_cycles < RSP_TIMEOUT) begin
        busy_cycles++;
        @(negedge clk);
    end
    check_val("busy cycles", busy_cycles, 32'd5);
    check_rsp(m_result, m_flags);
    run_op(ALU_ADD, W_LONG, next_rand(), next_rand());  // held until busy fell
    finish_test("handshake");
endtask

task automatic test_reset_state();
    run_op(ALU_SUB, W_BYTE, 32'h10, 32'h21);
    run_op(ALU_EXFF, W_LONG, 32'd0, 32'd0);     // nonzero flags into the shadow
    run_op(ALU_SUB, W_BYTE, 32'h10, 32'h21);
    drive_req(ALU_SRL, W_LONG, 32'hffff_ffff, 32'd0);
    @(posedge clk);
    req_valid <= 1'b0;
    apply_reset();      // lands in the middle of the shift
    check_val("busy", {31'd0, busy}, 32'd0);
    check_val("rsp_valid", {31'd0, rsp_valid}, 32'd0);
    check_val("result", result, 32'd0);
    check_val("flags", {26'd0, flags}, 32'd0);
    run_op(ALU_EXFF, W_LONG, 32'd0, 32'd0);     // shadow cleared as well
    finish_test("reset state");
endtask

/* verification/alu_tb.sv */
// Testbench for the 32-bit ALU top level with the directed tests of alu_tests.svh.
// A behavioral model of the result and flag rules predicts every response.
// Operands come from an LCG with a fixed seed.
// Inputs change on the rising edge and outputs are sampled on the falling edge.
// Requests are never raised while busy is high, as the DUT requires.
`timescale 1ns/1ps
`default_nettype none

module alu_tb;

    import alu_isa_pkg::*;
    import alu_status_pkg::*;

    localparam int CLK_NS      = 20;
    localparam int RSP_TIMEOUT = 40;    // cycles per request
    localparam int RUN_CYCLES  = 720 + 150 + 100 + 680 + 30 + 20;
    localparam int WATCHDOG_NS = RUN_CYCLES * CLK_NS * 3 / 2;

    logic        clk;
    logic        rst;
    logic        req_valid;
    alu_req_t    req;
    logic        busy;
    logic        rsp_valid;
    logic [31:0] result;
    alu_flags_t  flags;

    logic [31:0] m_result;  // model state
    alu_flags_t  m_flags;
    alu_flags_t  m_shadow;
    logic [31:0] lcg_state;
    int          test_errs;
    int          total_errs;
    int          checks;
    int          tests_run;

    alu_top dut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .result    (result),
        .flags     (flags)
    );

    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, exp, got);
            test_errs++;
        end
    endtask

    task automatic check_rsp(input logic [31:0] exp_res, input alu_flags_t exp_flg);
        checks++;
        assert (rsp_valid === 1'b1 && busy === 1'b0) else begin
            $display("no response pulse at %0t ns (rsp_valid=%b busy=%b)",
                     $time, rsp_valid, busy);
            test_errs++;
        end
        check_val("result", result, exp_res);
        check_val("flags", {26'd0, flags}, {26'd0, exp_flg});
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d errors", name, test_errs);
        total_errs += test_errs;
        tests_run++;
        test_errs = 0;
    endtask

    task automatic release_reset();
        repeat (3) @(posedge clk);
        rst      <= 1'b0;
        m_result = '0;
        m_flags  = '0;
        m_shadow = '0;
        @(negedge clk);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst       <= 1'b1;
        req_valid <= 1'b0;
        release_reset();
    endtask

    // predicts result, flags and latency, then advances the model state
    task automatic model_step(input alu_op_e op, input alu_width_e w,
                              input logic [31:0] a, input logic [31:0] b, output int lat);
        logic [31:0] m;
        logic [31:0] r;
        logic [31:0] val;
        logic [32:0] aw;
        logic [32:0] bw;
        logic [32:0] full;
        logic        ci;
        logic        c;
        logic        in_bit;
        logic        out_bit;
        int          nb;
        int          i;
        int          cnt;
        alu_flags_t  f;
        case (w)
            W_BYTE: begin
                nb = 8;
                m  = 32'h0000_00ff;
            end
            W_WORD: begin
                nb = 16;
                m  = 32'h0000_ffff;
            end
            default: begin
                nb = 32;
                m  = 32'hffff_ffff;
            end
        endcase
        f   = m_flags;
        r   = m_result;     // kept unless the op writes it
        lat = 1;
        aw  = {1'b0, a & m};
        bw  = {1'b0, b & m};
        case (op)
            ALU_ADD, ALU_ADC: begin
                ci   = op == ALU_ADC && m_flags.c;
                full = aw + bw + {32'd0, ci};
                val  = full[31:0] & m;
                r    = val;
                f.s  = val[nb-1];
                f.z  = val == 32'd0;
                f.h  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, ci} > 5'd15;
                f.v  = a[nb-1] == b[nb-1] && val[nb-1] != a[nb-1];
                f.n  = 1'b0;
                f.c  = full[nb];
            end
            ALU_SUB, ALU_SBC, ALU_CP: begin
                ci   = op == ALU_SBC && m_flags.c;
                full = aw - bw - {32'd0, ci};
                val  = full[31:0] & m;
                if (op != ALU_CP) begin
                    r = val;
                end
                f.s  = val[nb-1];
                f.z  = val == 32'd0;
                f.h  = {1'b0, a[3:0]} < {1'b0, b[3:0]} + {4'd0, ci};  // nibble borrow
                f.v  = a[nb-1] != b[nb-1] && val[nb-1] != a[nb-1];
                f.n  = 1'b1;
                f.c  = aw < bw + {32'd0, ci};
            end
            ALU_AND, ALU_OR, ALU_XOR: begin
                case (op)
                    ALU_AND: val = a & b;
                    ALU_OR:  val = a | b;
                    default: val = a ^ b;
                endcase
                val = val & m;
                r   = val;
                f.s = val[nb-1];
                f.z = val == 32'd0;
                f.h = op == ALU_AND;
                f.v = ~^val;    // even parity
                f.n = 1'b0;
                f.c = 1'b0;
            end
            ALU_SCF, ALU_RCF: begin
                f.h = 1'b0;
                f.n = 1'b0;
                f.c = op == ALU_SCF;
            end
            ALU_CCF: begin
                f.n = 1'b0;
                f.c = ~m_flags.c;
            end
            ALU_ZCF: begin
                f.n = 1'b0;
                f.c = ~m_flags.z;
            end
            ALU_EXFF: begin
                f        = m_shadow;
                m_shadow = m_flags;
            end
            ALU_RLC, ALU_RRC, ALU_RL, ALU_RR, ALU_SLA, ALU_SRA, ALU_SLL, ALU_SRL: begin
                val = a & m;
                c   = m_flags.c;
                cnt = (b[3:0] == 4'd0) ? 16 : int'(b[3:0]);
                for (i = 0; i < cnt; i++) begin
                    if (op inside {ALU_RLC, ALU_RL, ALU_SLA, ALU_SLL}) begin
                        out_bit = val[nb-1];
                        in_bit  = (op == ALU_RLC) ? val[nb-1] : (op == ALU_RL) ? c : 1'b0;
                        val     = ((val << 1) | {31'd0, in_bit}) & m;
                    end else begin
                        out_bit = val[0];
                        in_bit  = (op == ALU_RRC) ? val[0] : (op == ALU_RR) ? c :
                                  (op == ALU_SRA) ? val[nb-1] : 1'b0;
                        val     = val >> 1;
                        val[nb-1] = in_bit;
                    end
                    c = out_bit;
                end
                r   = val;
                f.s = val[nb-1];
                f.z = val == 32'd0;
                f.h = 1'b0;
                f.v = ~^val;
                f.n = 1'b0;
                f.c = c;    // last bit out
                lat = cnt + 1;
            end
            default: ;
        endcase
        m_result = r;
        m_flags  = f;
    endtask

    task automatic drive_req(input alu_op_e op, input alu_width_e w,
                             input logic [31:0] a, input logic [31:0] b);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= '{op: op, width: w, a: a, b: b};
    endtask

    // send one request and compare its response with the model
    task automatic run_op(input alu_op_e op, input alu_width_e w,
                          input logic [31:0] a, input logic [31:0] b);
        int exp_lat;
        int lat;
        model_step(op, w, a, b, exp_lat);
        drive_req(op, w, a, b);
        @(posedge clk);
        req_valid <= 1'b0;
        lat = 1;
        @(negedge clk);
        while (rsp_valid !== 1'b1 && lat < RSP_TIMEOUT) begin
            assert (busy === 1'b1) else begin
                $display("busy low at %0t ns while %s had no response", $time, op.name());
                test_errs++;
            end
            lat++;
            @(negedge clk);
        end
        check_val("latency", lat, exp_lat);
        check_rsp(m_result, m_flags);
    endtask

    `include "alu_tests.svh"

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        lcg_state  = 32'h39fc_e4d4;
        test_errs  = 0;
        total_errs = 0;
        checks     = 0;
        tests_run  = 0;
        release_reset();
        test_arith();
        test_logic();
        test_flag_ops();
        test_shifts();
        test_handshake();
        test_reset_state();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, total_errs);
        if (total_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* alu900.f */
+incdir+verification
logic/alu_isa_pkg.sv
logic/alu_status_pkg.sv
logic/alu_arith.sv
logic/alu_shifter.sv
logic/alu_flag_reg.sv
logic/alu_top.sv
verification/alu_tb.sv

/* Makefile */
# Verilator build and run of the alu900 testbench.
# Override any variable on the command line, e.g. make TOP=alu_top lint

VERILATOR ?= verilator
TOP       ?= alu_tb
FILELIST  ?= alu900.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_TEXT ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the simulation prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
